//--- sim/main_bus_stim.txt
# op port write addr wdata strb exp_rdata exp_err, all hex
# op 1 transfer, 2 paired with next line, 3 vram gated by blank, 4 lvbl/lhbl from wdata
# 5 mcu_irq pulse, 6 ext_irq_n from wdata, 7 expect ipl, 8 expect latch (port selects)
07 0 0 0000 0000 0 0000 0
01 0 1 0020 1111 3 0000 0
01 0 1 0020 AB00 2 0000 0
01 1 1 0020 00CD 1 0000 0
01 0 0 0020 0000 0 ABCD 0
01 1 0 0020 0000 0 ABCD 0
01 1 1 0040 55AA 3 0000 0
01 0 1 0040 FFFF 0 0000 0
01 1 0 0040 0000 0 55AA 0
02 0 1 0060 2222 3 0000 0
01 1 1 0062 3333 3 0000 0
02 0 0 0062 0000 0 3333 0
01 1 0 0060 0000 0 2222 0
03 0 1 4010 1234 3 0000 0
04 0 0 0000 0002 0 0000 0
01 1 0 4010 0000 0 1234 0
04 0 0 0000 0003 0 0000 0
01 0 1 C010 0005 3 0000 0
01 0 1 C012 00A7 3 0000 0
01 1 1 C014 1357 3 0000 0
08 0 0 0000 0000 0 0005 0
08 1 0 0000 0000 0 00A7 0
08 2 0 0000 0000 0 1357 0
01 0 0 C000 0000 0 3CA5 0
01 1 0 C002 0000 0 FF59 0
01 0 0 C004 0000 0 C35A 0
01 0 0 C006 0000 0 FFFF 1
01 1 0 8000 0000 0 FFFF 1
05 0 0 0000 0000 0 0000 0
07 0 0 0000 0000 0 0005 0
04 0 0 0000 0001 0 0000 0
07 0 0 0000 0000 0 0006 0
04 0 0 0000 0003 0 0000 0
01 0 1 C016 0000 3 0000 0
07 0 0 0000 0000 0 0005 0
06 0 0 0000 0000 0 0000 0
01 1 0 C008 0000 0 BEEF 0
07 0 0 0000 0000 0 0004 0
06 0 0 0000 0001 0 0000 0
07 0 0 0000 0000 0 0000 0

//--- src.f
hdl/main_bus_pkg.sv
hdl/bus_arbiter.sv
hdl/addr_decoder.sv
hdl/sys_regs.sv
hdl/vram_gate.sv
hdl/work_ram.sv
hdl/main_bus_top.sv
sim/main_bus_checker.sv
sim/main_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the main bus testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module main_bus_tb \
    -f src.f -Mdir obj_dir -o main_bus_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/main_bus_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$log"; then
    exit 1
fi
exit 0

//--- sim/main_bus_tb.sv
module main_bus_tb;
    import main_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int GATE_CYCLES    = 6;   // display cycles before lhbl falls

    // one line of the stim file
    typedef struct packed {
        logic [7:0]  op;
        logic [7:0]  port;
        logic [7:0]  write;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [7:0]  strb;
        logic [15:0] exp_rdata;
        logic [7:0]  exp_err;
    } stim_op_t;

    logic        clk;
    logic        rst;
    apb_req_t    m0_req;
    apb_rsp_t    m0_rsp;
    apb_req_t    m1_req;
    apb_rsp_t    m1_rsp;
    logic [8:0]  joystick1;
    logic [8:0]  joystick2;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic        lvbl;
    logic        lhbl;
    logic        ext_irq_n;
    logic [15:0] mcu_dout;
    logic        mcu_irq;
    logic [15:0] mcu_din;
    logic [7:0]  snd_latch;
    logic        snd_req;
    logic [2:0]  prisel;
    logic [2:0]  ipl;

    int          errors;
    int          overlap_errors;
    int          timeouts;
    int          snd_pulses;
    int          snd_writes;
    integer      seed;
    logic [15:0] wram_model [WRAM_WORDS];
    logic [15:0] vram_model [VRAM_WORDS];
    apb_rsp_t    got_rsp [2];
    bit          got_ok [2];

    main_bus_top u_main_bus_top (
        .clk          (clk),
        .rst          (rst),
        .m0_req       (m0_req),
        .m0_rsp       (m0_rsp),
        .m1_req       (m1_req),
        .m1_rsp       (m1_rsp),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .lvbl         (lvbl),
        .lhbl         (lhbl),
        .ext_irq_n    (ext_irq_n),
        .mcu_dout     (mcu_dout),
        .mcu_irq      (mcu_irq),
        .mcu_din      (mcu_din),
        .snd_latch    (snd_latch),
        .snd_req      (snd_req),
        .prisel       (prisel),
        .ipl          (ipl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst && m0_rsp.ready && m1_rsp.ready) begin
            overlap_errors++;
            $display("Error at %0t: both ports saw ready together", $time);
        end
        if (!rst && snd_req) begin
            snd_pulses++;   // high cycles of the sound strobe
        end
    end

    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] wdata,
                                                input logic [1:0]  strb);
        logic [15:0] word;
        word = old;
        if (strb[0]) word[7:0] = wdata[7:0];
        if (strb[1]) word[15:8] = wdata[15:8];
        return word;
    endfunction

    task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input bit with_data,
                             input string what);
        if (got.slverr !== exp.slverr || (with_data && got.rdata !== exp.rdata)) begin
            errors++;
            $display("Error at %0t: %s rdata %h slverr %b, expected rdata %h slverr %b",
                     $time, what, got.rdata, got.slverr, exp.rdata, exp.slverr);
        end
    endtask

    task automatic check_ipl(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: ipl %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_latch(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pulses(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Error at %0t: %s high for %0d cycles, expected %0d",
                     $time, name, got, exp);
        end
    endtask

    task automatic drive_port(input bit port, input apb_req_t req);
        if (port) m1_req = req;
        else m0_req = req;
    endtask

    function automatic apb_rsp_t port_rsp(input bit port);
        return port ? m1_rsp : m0_rsp;
    endfunction

    // setup phase, access phase, then wait for ready
    task automatic run_transfer(input bit port, input bit write, input logic [15:0] addr,
                                input logic [15:0] wdata, input logic [1:0] strb,
                                input int gate_cycles);
        apb_req_t req;
        apb_rsp_t rsp;
        int       cycles;
        req       = '0;
        req.sel   = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        req.strb  = strb;
        @(posedge clk);
        #10;
        drive_port(port, req);
        @(posedge clk);
        #10;
        req.enable = 1'b1;
        drive_port(port, req);
        cycles = 0;
        @(negedge clk);
        rsp = port_rsp(port);
        while (!rsp.ready && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #10;
            if (gate_cycles > 0 && cycles + 1 == gate_cycles) lhbl = 1'b0;   // display goes dark
            @(negedge clk);
            rsp = port_rsp(port);
            cycles++;
        end
        if (gate_cycles > 0 && rsp.ready && cycles < gate_cycles) begin
            errors++;
            $display("Error at %0t: video RAM ready during active display", $time);
        end
        @(posedge clk);
        #10;
        drive_port(port, '0);
        if (gate_cycles > 0) lhbl = 1'b1;
        got_rsp[port] = rsp;
        got_ok[port]  = rsp.ready;
        if (!rsp.ready) begin
            timeouts++;
            $display("port %0d got no ready for address %h within %0d cycles",
                     port, addr, TIMEOUT_CYCLES);
        end
    endtask

    task automatic check_result(input stim_op_t s);
        apb_rsp_t    exp;
        bit          port;
        logic [15:0] off;
        port       = s.port[0];
        exp.ready  = 1'b1;
        exp.slverr = s.exp_err[0];
        exp.rdata  = s.exp_rdata;
        off        = s.addr - VRAM_BASE;
        if (got_ok[port]) begin
            check_rsp(got_rsp[port], exp, !s.write[0], "stim");
            if (s.write[0] && !s.exp_err[0] && s.addr == SYS_BASE + SYS_SND) begin
                snd_writes++;   // each sound write strobes snd_req once
            end
            if (s.addr < 16'(2 * WRAM_WORDS)) begin
                if (s.write[0]) begin
                    wram_model[s.addr[9:1]] = merge_bytes(wram_model[s.addr[9:1]],
                                                          s.wdata, s.strb[1:0]);
                end else begin
                    exp.rdata = wram_model[s.addr[9:1]];
                    check_rsp(got_rsp[port], exp, 1'b1, "work RAM model");
                end
            end else if (off < 16'(2 * VRAM_WORDS)) begin
                if (s.write[0]) begin
                    vram_model[off[8:1]] = merge_bytes(vram_model[off[8:1]],
                                                       s.wdata, s.strb[1:0]);
                end else begin
                    exp.rdata = vram_model[off[8:1]];
                    check_rsp(got_rsp[port], exp, 1'b1, "video RAM model");
                end
            end
        end
    endtask

    // skips comment and blank lines
    task automatic read_op(input int fd, output stim_op_t s, output bit found);
        string       line;
        int          r;
        int          n;
        logic [7:0]  f_op;
        logic [7:0]  f_port;
        logic [7:0]  f_wr;
        logic [15:0] f_addr;
        logic [15:0] f_wdata;
        logic [7:0]  f_strb;
        logic [15:0] f_rdata;
        logic [7:0]  f_err;
        found = 1'b0;
        s     = '0;
        while (!found && !$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_port, f_wr, f_addr,
                        f_wdata, f_strb, f_rdata, f_err);
            if (r > 0 && n == 8) begin
                found       = 1'b1;
                s.op        = f_op;
                s.port      = f_port;
                s.write     = f_wr;
                s.addr      = f_addr;
                s.wdata     = f_wdata;
                s.strb      = f_strb;
                s.exp_rdata = f_rdata;
                s.exp_err   = f_err;
            end
        end
    endtask

    task automatic run_op(input stim_op_t s);
        case (s.op)
            8'h1, 8'h3: begin
                run_transfer(s.port[0], s.write[0], s.addr, s.wdata, s.strb[1:0],
                             (s.op == 8'h3) ? GATE_CYCLES : 0);
                check_result(s);
            end
            8'h4: begin
                @(posedge clk);
                #10;
                lvbl = s.wdata[1];
                lhbl = s.wdata[0];
            end
            8'h5: begin
                @(posedge clk);
                #10;
                mcu_irq = 1'b1;
                @(posedge clk);
                #10;
                mcu_irq = 1'b0;
            end
            8'h6: begin
                @(posedge clk);
                #10;
                ext_irq_n = s.wdata[0];
            end
            8'h7: begin
                @(posedge clk);   // let the interrupt flags latch
                @(negedge clk);
                check_ipl(ipl, s.exp_rdata[2:0]);
            end
            8'h8: begin
                @(negedge clk);
                case (s.port)
                    8'h0: check_latch("prisel", 16'(prisel), s.exp_rdata);
                    8'h1: check_latch("snd_latch", 16'(snd_latch), s.exp_rdata);
                    default: check_latch("mcu_din", mcu_din, s.exp_rdata);
                endcase
            end
            default: begin
                errors++;
                $display("unknown operation code %h in the stim file", s.op);
            end
        endcase
    endtask

    initial begin
        stim_op_t a;
        stim_op_t b;
        bit       found;
        int       fd;
        int       ops;
        int       gap;
        errors         = 0;
        overlap_errors = 0;
        timeouts       = 0;
        snd_pulses     = 0;
        snd_writes     = 0;
        ops            = 0;
        seed           = 71;
        m0_req         = '0;
        m1_req         = '0;
        joystick1      = 9'h1A5;
        joystick2      = 9'h03C;
        start_button   = 2'b10;
        coin_input     = 2'b01;
        service        = 1'b1;
        dipsw_a        = 8'h5A;
        dipsw_b        = 8'hC3;
        lvbl           = 1'b1;
        lhbl           = 1'b1;
        ext_irq_n      = 1'b1;
        mcu_dout       = 16'hBEEF;
        mcu_irq        = 1'b0;
        rst            = 1'b1;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        fd = $fopen("sim/main_bus_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stim file sim/main_bus_stim.txt");
        end else begin
            found = 1'b1;
            while (found && timeouts == 0) begin
                read_op(fd, a, found);
                if (found) begin
                    ops++;
                    gap = $random(seed) & 3;   // idle cycles between operations
                    repeat (gap) @(posedge clk);
                    if (a.op == 8'h2) begin
                        read_op(fd, b, found);
                        if (!found || b.port[0] == a.port[0]) begin
                            errors++;
                            $display("paired transfer in the stim file has no partner port");
                        end else begin
                            fork
                                run_transfer(a.port[0], a.write[0], a.addr, a.wdata,
                                             a.strb[1:0], 0);
                                run_transfer(b.port[0], b.write[0], b.addr, b.wdata,
                                             b.strb[1:0], 0);
                            join
                            check_result(a);
                            check_result(b);
                        end
                    end else begin
                        run_op(a);
                    end
                end
            end
            $fclose(fd);
        end
        if (ops == 0) begin
            errors++;
            $display("the stim file held no operations");
        end

        @(negedge clk);
        check_pulses("snd_req", snd_pulses, snd_writes);
        errors = errors + overlap_errors;
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim/main_bus_checker.sv
module main_bus_checker (
    input logic                   clk,
    input logic                   rst,
    input main_bus_pkg::apb_req_t m0_req,
    input main_bus_pkg::apb_rsp_t m0_rsp,
    input main_bus_pkg::apb_req_t m1_req,
    input main_bus_pkg::apb_rsp_t m1_rsp,
    input main_bus_pkg::apb_req_t bus_req,
    input main_bus_pkg::apb_rsp_t bus_rsp
);

    // a port is answered only while the bus carries its own request
    own_ready: assert property (@(posedge clk) disable iff (rst)
        !(m0_rsp.ready && bus_req != m0_req) && !(m1_rsp.ready && bus_req != m1_req))
        else $error("a port saw ready for a request that is not its own");

    // access phase only follows a setup phase of the same transfer
    enable_with_sel: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_req.enable) |-> bus_req.sel && $past(bus_req.sel && !bus_req.enable))
        else $error("enable rose without a setup phase");

    // access phase holds the request until the slave answers
    held_in_access: assert property (@(posedge clk) disable iff (rst)
        (bus_req.enable && !bus_rsp.ready) |=> $stable(bus_req))
        else $error("bus request changed while waiting for ready");

endmodule

bind bus_arbiter main_bus_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .m0_req  (m0_req),
    .m0_rsp  (m0_rsp),
    .m1_req  (m1_req),
    .m1_rsp  (m1_rsp),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
);

//--- hdl/main_bus_top.sv
module main_bus_top (
    input  logic                   clk,
    input  logic                   rst,
    input  main_bus_pkg::apb_req_t m0_req,
    output main_bus_pkg::apb_rsp_t m0_rsp,
    input  main_bus_pkg::apb_req_t m1_req,
    output main_bus_pkg::apb_rsp_t m1_rsp,
    input  logic [8:0]             joystick1,
    input  logic [8:0]             joystick2,
    input  logic [1:0]             start_button,
    input  logic [1:0]             coin_input,
    input  logic                   service,
    input  logic [7:0]             dipsw_a,
    input  logic [7:0]             dipsw_b,
    input  logic                   lvbl,
    input  logic                   lhbl,
    input  logic                   ext_irq_n,
    input  logic [15:0]            mcu_dout,
    input  logic                   mcu_irq,
    output logic [15:0]            mcu_din,
    output logic [7:0]             snd_latch,
    output logic                   snd_req,
    output logic [2:0]             prisel,
    output logic [2:0]             ipl
);
    import main_bus_pkg::*;

    apb_req_t bus_req;
    apb_rsp_t bus_rsp;
    apb_req_t wram_req;
    apb_rsp_t wram_rsp;
    apb_req_t vram_req;
    apb_rsp_t vram_rsp;
    apb_req_t sys_req;
    apb_rsp_t sys_rsp;

    bus_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .m0_req  (m0_req),
        .m0_rsp  (m0_rsp),
        .m1_req  (m1_req),
        .m1_rsp  (m1_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    addr_decoder u_decoder (
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .wram_req (wram_req),
        .wram_rsp (wram_rsp),
        .vram_req (vram_req),
        .vram_rsp (vram_rsp),
        .sys_req  (sys_req),
        .sys_rsp  (sys_rsp)
    );

    sys_regs u_sys_regs (
        .clk          (clk),
        .rst          (rst),
        .req          (sys_req),
        .rsp          (sys_rsp),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .lvbl         (lvbl),
        .ext_irq_n    (ext_irq_n),
        .mcu_dout     (mcu_dout),
        .mcu_irq      (mcu_irq),
        .mcu_din      (mcu_din),
        .snd_latch    (snd_latch),
        .snd_req      (snd_req),
        .prisel       (prisel),
        .ipl          (ipl)
    );

    vram_gate u_vram (
        .clk  (clk),
        .rst  (rst),
        .req  (vram_req),
        .rsp  (vram_rsp),
        .lvbl (lvbl),
        .lhbl (lhbl)
    );

    work_ram u_wram (
        .clk (clk),
        .rst (rst),
        .req (wram_req),
        .rsp (wram_rsp)
    );

endmodule

//--- hdl/work_ram.sv
module work_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  main_bus_pkg::apb_req_t req,
    output main_bus_pkg::apb_rsp_t rsp
);
    import main_bus_pkg::*;

    localparam int AW = $clog2(WRAM_WORDS);

    logic [15:0]   mem [WRAM_WORDS];
    logic [15:0]   off;
    logic [AW-1:0] idx;
    logic [15:0]   rdata_q;
    logic          access;
    logic          waited;   // one wait state spent

    assign off    = req.addr - WRAM_BASE;
    assign idx    = off[AW:1];
    assign access = req.sel & req.enable;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waited <= 1'b0;
        end else if (access) begin
            waited <= ~waited;   // set in the first cycle, dropped with ready
        end
    end

    // read data registered from the first access cycle
    always_ff @(posedge clk) begin
        rdata_q <= mem[idx];
        if (access && waited && req.write) begin
            if (req.strb[0]) mem[idx][7:0] <= req.wdata[7:0];
            if (req.strb[1]) mem[idx][15:8] <= req.wdata[15:8];
        end
    end

    assign rsp.ready  = access & waited;
    assign rsp.slverr = 1'b0;
    assign rsp.rdata  = rdata_q;

endmodule

//--- hdl/vram_gate.sv
module vram_gate (
    input  logic                   clk,
    input  logic                   rst,
    input  main_bus_pkg::apb_req_t req,
    output main_bus_pkg::apb_rsp_t rsp,
    input  logic                   lvbl,
    input  logic                   lhbl
);
    import main_bus_pkg::*;

    localparam int AW = $clog2(VRAM_WORDS);

    logic [15:0]   mem [VRAM_WORDS];
    logic [15:0]   off;
    logic [AW-1:0] idx;
    logic [15:0]   rdata_q;
    logic          access;
    logic          blank;
    logic          blank_l;
    logic          blank_rise;
    logic          pending;
    logic [1:0]    cnt;     // 0 while waiting for blank
    logic          done;

    assign off        = req.addr - VRAM_BASE;
    assign idx        = off[AW:1];
    assign access     = req.sel & req.enable;
    assign blank      = ~lvbl | ~lhbl;
    assign blank_rise = blank & ~blank_l;
    assign done       = pending & (cnt == 2'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_l <= 1'b0;
            pending <= 1'b0;
            cnt     <= '0;
        end else begin
            blank_l <= blank;
            if (done) begin
                pending <= 1'b0;
                cnt     <= '0;
            end else if (access && !pending) begin
                pending <= 1'b1;
                cnt     <= blank ? 2'd2 : 2'd0;   // inside blank counts at once
            end else if (pending && cnt == 2'd0) begin
                if (blank_rise) cnt <= 2'd2;   // display just went dark
            end else if (pending) begin
                cnt <= cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= mem[idx];
        if (done && req.write) begin
            if (req.strb[0]) mem[idx][7:0] <= req.wdata[7:0];
            if (req.strb[1]) mem[idx][15:8] <= req.wdata[15:8];
        end
    end

    assign rsp.ready  = access & done;
    assign rsp.slverr = 1'b0;
    assign rsp.rdata  = rdata_q;

endmodule

//--- hdl/sys_regs.sv
module sys_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  main_bus_pkg::apb_req_t req,
    output main_bus_pkg::apb_rsp_t rsp,
    input  logic [8:0]             joystick1,
    input  logic [8:0]             joystick2,
    input  logic [1:0]             start_button,
    input  logic [1:0]             coin_input,
    input  logic                   service,
    input  logic [7:0]             dipsw_a,
    input  logic [7:0]             dipsw_b,
    input  logic                   lvbl,
    input  logic                   ext_irq_n,    // active low
    input  logic [15:0]            mcu_dout,
    input  logic                   mcu_irq,
    output logic [15:0]            mcu_din,
    output logic [7:0]             snd_latch,
    output logic                   snd_req,
    output logic [2:0]             prisel,
    output logic [2:0]             ipl
);
    import main_bus_pkg::*;

    logic [15:0] off;
    logic        access;
    logic        wr;
    logic        rd;
    logic        rd_hit;
    logic        wr_hit;
    logic [15:0] rd_data;
    logic        vint;
    logic        mcu_int;
    logic        lvbl_l;
    logic        mcu_irq_l;

    assign off    = req.addr - SYS_BASE;
    assign access = req.sel & req.enable;
    assign wr     = access & req.write;
    assign rd     = access & ~req.write;

    always_comb begin
        rd_data = OPEN_BUS;
        rd_hit  = 1'b1;
        case (off)
            SYS_JOY:     rd_data = {joystick2[7:0], joystick1[7:0]};
            SYS_INPUTS:  rd_data = {8'hFF, ~lvbl, service, coin_input, start_button,
                                    joystick2[8], joystick1[8]};
            SYS_DIP:     rd_data = {dipsw_b, dipsw_a};
            SYS_MBOX_IN: rd_data = mcu_dout;
            default:     rd_hit  = 1'b0;
        endcase
    end

    assign wr_hit = (off == SYS_PRIO) || (off == SYS_SND) ||
                    (off == SYS_MBOX_OUT) || (off == SYS_VINT_CLR);

    // zero wait states
    assign rsp.ready  = access;
    assign rsp.slverr = access & (req.write ? ~wr_hit : ~rd_hit);
    assign rsp.rdata  = rd_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prisel    <= '0;
            snd_latch <= '0;
            snd_req   <= 1'b0;
            mcu_din   <= '0;
            vint      <= 1'b0;
            mcu_int   <= 1'b0;
            lvbl_l    <= 1'b0;
            mcu_irq_l <= 1'b0;
        end else begin
            lvbl_l    <= lvbl;
            mcu_irq_l <= mcu_irq;
            snd_req   <= wr && (off == SYS_SND);   // one cycle strobe to the sound CPU

            if (wr && off == SYS_PRIO) prisel <= req.wdata[2:0];
            if (wr && off == SYS_SND) snd_latch <= req.wdata[7:0];
            if (wr && off == SYS_MBOX_OUT) mcu_din <= req.wdata;

            if (wr && off == SYS_VINT_CLR) begin
                vint <= 1'b0;
            end else if (!lvbl && lvbl_l) begin
                vint <= 1'b1;   // start of vertical blank
            end

            // reading the mailbox acknowledges the MCU
            if (rd && off == SYS_MBOX_IN) begin
                mcu_int <= 1'b0;
            end else if (mcu_irq && !mcu_irq_l) begin
                mcu_int <= 1'b1;
            end
        end
    end

    always_comb begin
        if (vint) begin
            ipl = IPL_VBL;
        end else if (mcu_int) begin
            ipl = IPL_MCU;
        end else if (!ext_irq_n) begin
            ipl = IPL_EXT;
        end else begin
            ipl = IPL_NONE;
        end
    end

endmodule

//--- hdl/addr_decoder.sv
module addr_decoder (
    input  main_bus_pkg::apb_req_t bus_req,
    output main_bus_pkg::apb_rsp_t bus_rsp,
    output main_bus_pkg::apb_req_t wram_req,
    input  main_bus_pkg::apb_rsp_t wram_rsp,
    output main_bus_pkg::apb_req_t vram_req,
    input  main_bus_pkg::apb_rsp_t vram_rsp,
    output main_bus_pkg::apb_req_t sys_req,
    input  main_bus_pkg::apb_rsp_t sys_rsp
);
    import main_bus_pkg::*;

    localparam logic [15:0] WRAM_BYTES = 16'(2 * WRAM_WORDS);
    localparam logic [15:0] VRAM_BYTES = 16'(2 * VRAM_WORDS);

    logic [15:0] wram_off;
    logic [15:0] vram_off;
    logic [15:0] sys_off;
    region_e     region;

    // offsets wrap below the base so one compare per window is enough
    assign wram_off = bus_req.addr - WRAM_BASE;
    assign vram_off = bus_req.addr - VRAM_BASE;
    assign sys_off  = bus_req.addr - SYS_BASE;

    always_comb begin
        if (wram_off < WRAM_BYTES) begin
            region = reg_wram;
        end else if (vram_off < VRAM_BYTES) begin
            region = reg_vram;
        end else if (sys_off < SYS_BYTES) begin
            region = reg_sys;
        end else begin
            region = reg_none;
        end
    end

    always_comb begin
        wram_req     = bus_req;
        wram_req.sel = bus_req.sel & (region == reg_wram);
        vram_req     = bus_req;
        vram_req.sel = bus_req.sel & (region == reg_vram);
        sys_req      = bus_req;
        sys_req.sel  = bus_req.sel & (region == reg_sys);
    end

    always_comb begin
        case (region)
            reg_wram: bus_rsp = wram_rsp;
            reg_vram: bus_rsp = vram_rsp;
            reg_sys:  bus_rsp = sys_rsp;
            default: begin
                // nobody home, end the access phase with an error
                bus_rsp.ready  = bus_req.sel & bus_req.enable;
                bus_rsp.slverr = bus_req.sel & bus_req.enable;
                bus_rsp.rdata  = OPEN_BUS;
            end
        endcase
    end

endmodule

//--- hdl/bus_arbiter.sv
module bus_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  main_bus_pkg::apb_req_t m0_req,   // main CPU
    output main_bus_pkg::apb_rsp_t m0_rsp,
    input  main_bus_pkg::apb_req_t m1_req,   // sound/protection MCU
    output main_bus_pkg::apb_rsp_t m1_rsp,
    output main_bus_pkg::apb_req_t bus_req,
    input  main_bus_pkg::apb_rsp_t bus_rsp
);
    import main_bus_pkg::*;

    logic     busy;
    logic     owner;    // 0 cpu, 1 mcu
    logic     last;     // owner of the previous transfer
    logic     setup;    // first granted cycle
    apb_req_t own_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            last  <= 1'b1;   // cpu wins the first tie
            setup <= 1'b0;
        end else if (!busy) begin
            if (m0_req.sel || m1_req.sel) begin
                busy  <= 1'b1;
                setup <= 1'b1;
                // round robin only matters when both ask
                owner <= (m0_req.sel && m1_req.sel) ? ~last : m1_req.sel;
            end
        end else begin
            setup <= 1'b0;
            if (bus_rsp.ready) begin
                busy <= 1'b0;   // released in the next cycle
                last <= owner;
            end
        end
    end

    // the bus sees a fresh setup phase even if the port
    // already waits in its access phase
    always_comb begin
        own_req = owner ? m1_req : m0_req;
        bus_req = '0;
        if (busy) begin
            bus_req        = own_req;
            bus_req.enable = own_req.enable & ~setup;
        end
    end

    // losing port sees nothing and keeps waiting
    assign m0_rsp = (busy && !owner) ? bus_rsp : '0;
    assign m1_rsp = (busy && owner)  ? bus_rsp : '0;

endmodule

//--- hdl/main_bus_pkg.sv
package main_bus_pkg;

    // APB request from a requester or towards a slave
    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [15:0] addr;    // byte address
        logic [15:0] wdata;
        logic [1:0]  strb;    // bit 1 upper byte, bit 0 lower byte
    } apb_req_t;

    typedef struct packed {
        logic        ready;
        logic        slverr;
        logic [15:0] rdata;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        reg_none,
        reg_wram,
        reg_vram,
        reg_sys
    } region_e;

    // address map
    localparam logic [15:0] WRAM_BASE  = 16'h0000;
    localparam logic [15:0] WRAM_WORDS = 16'd512;
    localparam logic [15:0] VRAM_BASE  = 16'h4000;
    localparam logic [15:0] VRAM_WORDS = 16'd256;
    localparam logic [15:0] SYS_BASE   = 16'hC000;
    localparam logic [15:0] SYS_BYTES  = 16'h0100;   // decoded span of the register block

    // system block read offsets
    localparam logic [15:0] SYS_JOY     = 16'h0000;
    localparam logic [15:0] SYS_INPUTS  = 16'h0002;
    localparam logic [15:0] SYS_DIP     = 16'h0004;
    localparam logic [15:0] SYS_MBOX_IN = 16'h0008;

    // system block write offsets
    localparam logic [15:0] SYS_PRIO     = 16'h0010;
    localparam logic [15:0] SYS_SND      = 16'h0012;
    localparam logic [15:0] SYS_MBOX_OUT = 16'h0014;
    localparam logic [15:0] SYS_VINT_CLR = 16'h0016;

    // interrupt levels, highest wins
    localparam logic [2:0] IPL_VBL  = 3'd6;
    localparam logic [2:0] IPL_MCU  = 3'd5;
    localparam logic [2:0] IPL_EXT  = 3'd4;
    localparam logic [2:0] IPL_NONE = 3'd0;

    localparam logic [15:0] OPEN_BUS = 16'hFFFF;

endpackage
